// File: itlb_pkg.sv
package itlb_pkg;

  // Default number of TLB entries
  localparam int I_TLB_ENTRIES = 4;

  // Sv39 field widths
  localparam int VPN_FIELD_W = 9;
  localparam int PPN_W       = 44;
  localparam int ASID_W      = 16;

  // Sv39 virtual page number, three 9-bit levels
  typedef struct packed {
    logic [VPN_FIELD_W-1:0] vpn2;
    logic [VPN_FIELD_W-1:0] vpn1;
    logic [VPN_FIELD_W-1:0] vpn0;
  } vpn_t;

  typedef logic [PPN_W-1:0]  ppn_t;
  typedef logic [ASID_W-1:0] asid_t;

  // Translation outcome
  typedef enum logic [1:0] {
    NoException,
    InstrPageFault,
    InstrAccessFault
  } exception_e;

  // Flush command from the system
  typedef enum logic [1:0] {
    NoFlush,
    FlushASID,
    FlushPage,
    FlushAll
  } tlb_flush_e;

  // Leaf page size
  typedef enum logic [1:0] {
    Page4K,
    Page2M,
    Page1G
  } page_size_e;

  // One TLB entry, 90 bits
  typedef struct packed {
    vpn_t       vpn;
    asid_t      asid;
    ppn_t       ppn;
    logic       glob;
    page_size_e size;
  } tlb_entry_t;

  // Answer to the instruction cache
  typedef struct packed {
    ppn_t       ppn;
    exception_e exc;
  } itlb_ans_t;

  // Leaf entry from the L2 / page walk
  typedef struct packed {
    ppn_t       ppn;
    logic       glob;
    page_size_e size;
    exception_e exc;
  } l2c_ans_t;

endpackage

// File: itlb_lookup.sv
module itlb_lookup #(
  parameter int N = itlb_pkg::I_TLB_ENTRIES
) (
  // Request to translate
  input  itlb_pkg::vpn_t       req_vpn_i,
  input  itlb_pkg::asid_t      current_asid_i,
  // Stored entries
  input  itlb_pkg::tlb_entry_t entries_i [N],
  input  logic [N-1:0]         valid_i,
  // Lookup result
  output logic                 hit_o,
  output itlb_pkg::ppn_t       hit_ppn_o
);

  import itlb_pkg::*;

  logic [N-1:0] match_vec;
  ppn_t         ppn_vec [N];

  // Per-entry tag compare
  always_comb begin
    for (int k = 0; k < N; k++) begin
      logic asid_ok;
      logic vpn_ok;
      // Global pages ignore the ASID
      asid_ok = entries_i[k].glob || (entries_i[k].asid == current_asid_i);
      // Compare only the levels above the page offset
      case (entries_i[k].size)
        Page1G: begin
          vpn_ok = (entries_i[k].vpn.vpn2 == req_vpn_i.vpn2);
        end
        Page2M: begin
          vpn_ok = (entries_i[k].vpn.vpn2 == req_vpn_i.vpn2) &&
                   (entries_i[k].vpn.vpn1 == req_vpn_i.vpn1);
        end
        default: begin
          vpn_ok = (entries_i[k].vpn == req_vpn_i);
        end
      endcase
      match_vec[k] = valid_i[k] && asid_ok && vpn_ok;
    end
  end

  // Physical page per entry, low bits of large pages from the VPN
  always_comb begin
    for (int k = 0; k < N; k++) begin
      ppn_vec[k] = entries_i[k].ppn;
      case (entries_i[k].size)
        Page1G: begin
          ppn_vec[k][2*VPN_FIELD_W-1:0] = {req_vpn_i.vpn1, req_vpn_i.vpn0};
        end
        Page2M: begin
          ppn_vec[k][VPN_FIELD_W-1:0] = req_vpn_i.vpn0;
        end
        default: begin
          ppn_vec[k] = entries_i[k].ppn;
        end
      endcase
    end
  end

  assign hit_o = |match_vec;

  // Priority select, scanning downward so the lowest index wins
  always_comb begin
    hit_ppn_o = '0;
    for (int k = N - 1; k >= 0; k--) begin
      if (match_vec[k]) begin
        hit_ppn_o = ppn_vec[k];
      end
    end
  end

endmodule

// File: itlb_ctrl.sv
module itlb_ctrl #(
  parameter int N = itlb_pkg::I_TLB_ENTRIES
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   vmem_on_i,
  // Cache request and lookup result
  input  logic                   icache_req_valid_i,
  input  itlb_pkg::vpn_t         icache_req_vpn_i,
  input  logic                   hit_i,
  // Latched walk exception
  input  itlb_pkg::exception_e   exc_q_i,
  // L2 side
  input  logic                   l2c_req_rdy_i,
  input  logic                   l2c_ans_valid_i,
  input  itlb_pkg::exception_e   l2c_ans_exc_i,
  // Flush command
  input  itlb_pkg::tlb_flush_e   flush_type_i,
  input  itlb_pkg::asid_t        flush_asid_i,
  input  itlb_pkg::vpn_t         flush_page_i,
  input  itlb_pkg::tlb_entry_t   entries_i [N],
  // Cache flow control
  output logic                   icache_req_rdy_o,
  output logic                   icache_ans_valid_o,
  // L2 request
  output logic                   l2c_req_valid_o,
  output itlb_pkg::vpn_t         l2c_req_vpn_o,
  // Entry array control
  output logic                   exc_reg_en_o,
  output logic                   exc_reg_clr_o,
  output logic                   replace_o,
  output logic [N-1:0]           flush_vec_o
);

  import itlb_pkg::*;

  typedef enum logic [1:0] {
    Ready,
    ReqL2,
    WaitL2
  } state_e;

  state_e state_q, state_d;
  vpn_t   miss_vpn_q;
  logic   miss;

  // Pending exception also counts as an answer
  assign miss = vmem_on_i && icache_req_valid_i && !hit_i && (exc_q_i == NoException);

  always_comb begin
    state_d            = state_q;
    icache_req_rdy_o   = 1'b0;
    icache_ans_valid_o = 1'b0;
    exc_reg_en_o       = 1'b0;
    exc_reg_clr_o      = 1'b0;
    replace_o          = 1'b0;
    case (state_q)
      Ready: begin
        if (!vmem_on_i || !icache_req_valid_i) begin
          // Identity path, or idle
          icache_req_rdy_o   = 1'b1;
          icache_ans_valid_o = icache_req_valid_i;
        end else if (!miss) begin
          // Hit or latched exception, answer and drop the exception
          icache_req_rdy_o   = 1'b1;
          icache_ans_valid_o = 1'b1;
          exc_reg_clr_o      = 1'b1;
        end else begin
          state_d = ReqL2;
        end
      end
      ReqL2: begin
        if (l2c_req_rdy_i) begin
          state_d = WaitL2;
        end
      end
      WaitL2: begin
        if (l2c_ans_valid_i) begin
          // Latch outcome, fill only on a clean leaf
          exc_reg_en_o = 1'b1;
          replace_o    = (l2c_ans_exc_i == NoException);
          state_d      = Ready;
        end
      end
      default: begin
        state_d = Ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= Ready;
    end else begin
      state_q <= state_d;
    end
  end

  // Missing VPN held for the walk and the fill
  always_ff @(posedge clk_i) begin
    if (state_q == Ready && miss) begin
      miss_vpn_q <= icache_req_vpn_i;
    end
  end

  assign l2c_req_valid_o = (state_q == ReqL2);
  assign l2c_req_vpn_o   = miss_vpn_q;

  // Flush selection per entry
  always_comb begin
    flush_vec_o = '0;
    for (int k = 0; k < N; k++) begin
      case (flush_type_i)
        FlushASID: begin
          // Global entries survive an ASID flush
          flush_vec_o[k] = (entries_i[k].asid == flush_asid_i) && !entries_i[k].glob;
        end
        FlushPage: begin
          case (entries_i[k].size)
            Page1G: flush_vec_o[k] = (entries_i[k].vpn.vpn2 == flush_page_i.vpn2);
            Page2M: flush_vec_o[k] = (entries_i[k].vpn.vpn2 == flush_page_i.vpn2) &&
                                     (entries_i[k].vpn.vpn1 == flush_page_i.vpn1);
            default: flush_vec_o[k] = (entries_i[k].vpn == flush_page_i);
          endcase
        end
        FlushAll: flush_vec_o[k] = 1'b1;
        default: flush_vec_o[k] = 1'b0;
      endcase
    end
  end

endmodule

// File: itlb_entries.sv
module itlb_entries #(
  parameter int N = itlb_pkg::I_TLB_ENTRIES
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Fill from the walk
  input  logic                 replace_i,
  input  itlb_pkg::vpn_t       fill_vpn_i,
  input  itlb_pkg::asid_t      fill_asid_i,
  input  itlb_pkg::l2c_ans_t   fill_ans_i,
  // Exception register control
  input  logic                 exc_reg_en_i,
  input  logic                 exc_reg_clr_i,
  // Entries to invalidate
  input  logic [N-1:0]         flush_vec_i,
  // Stored state
  output itlb_pkg::tlb_entry_t entries_o [N],
  output logic [N-1:0]         valid_o,
  output itlb_pkg::exception_e exc_q_o
);

  import itlb_pkg::*;

  // Pointer width, kept at least one bit
  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  tlb_entry_t       entries_q [N];
  logic [N-1:0]     valid_q;
  logic [PTR_W-1:0] rr_ptr_q;
  exception_e       exc_q;
  tlb_entry_t       new_entry;

  // Entry built from the leaf and the missing VPN
  always_comb begin
    new_entry.vpn  = fill_vpn_i;
    new_entry.asid = fill_asid_i;
    new_entry.ppn  = fill_ans_i.ppn;
    new_entry.glob = fill_ans_i.glob;
    new_entry.size = fill_ans_i.size;
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (replace_i) begin
      entries_q[rr_ptr_q] <= new_entry;
    end
  end

  // Valid bits, flush first then fill
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      for (int k = 0; k < N; k++) begin
        if (replace_i && (rr_ptr_q == PTR_W'(k))) begin
          valid_q[k] <= 1'b1;
        end else if (flush_vec_i[k]) begin
          valid_q[k] <= 1'b0;
        end
      end
    end
  end

  // Round-robin victim pointer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q <= '0;
    end else if (replace_i) begin
      if (rr_ptr_q == PTR_W'(N - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= rr_ptr_q + 1'b1;
      end
    end
  end

  // Walk exception, held until answered
  always_ff @(posedge clk_i) begin
    if (reset_i || exc_reg_clr_i) begin
      exc_q <= NoException;
    end else if (exc_reg_en_i) begin
      exc_q <= fill_ans_i.exc;
    end
  end

  assign entries_o = entries_q;
  assign valid_o   = valid_q;
  assign exc_q_o   = exc_q;

endmodule

// File: itlb_top.sv
module itlb_top #(
  parameter int N_ENTRIES = itlb_pkg::I_TLB_ENTRIES
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // System side
  input  logic                 vmem_on_i,
  input  itlb_pkg::asid_t      current_asid_i,
  input  itlb_pkg::tlb_flush_e flush_type_i,
  input  itlb_pkg::asid_t      flush_asid_i,
  input  itlb_pkg::vpn_t       flush_page_i,
  // Instruction cache side
  input  logic                 icache_req_valid_i,
  input  itlb_pkg::vpn_t       icache_req_vpn_i,
  output logic                 icache_req_rdy_o,
  output logic                 icache_ans_valid_o,
  output itlb_pkg::itlb_ans_t  icache_ans_o,
  // L2 / page walk side
  output logic                 l2c_req_valid_o,
  output itlb_pkg::vpn_t       l2c_req_vpn_o,
  input  logic                 l2c_req_rdy_i,
  input  logic                 l2c_ans_valid_i,
  input  itlb_pkg::l2c_ans_t   l2c_ans_i
);

  import itlb_pkg::*;

  tlb_entry_t           entries [N_ENTRIES];
  logic [N_ENTRIES-1:0] valid;
  logic [N_ENTRIES-1:0] flush_vec;
  logic                 hit;
  ppn_t                 hit_ppn;
  exception_e           exc_q;
  logic                 replace;
  logic                 exc_reg_en;
  logic                 exc_reg_clr;

  // Tag lookup
  itlb_lookup #(.N(N_ENTRIES)) u_lookup (
    .req_vpn_i      (icache_req_vpn_i),
    .current_asid_i (current_asid_i),
    .entries_i      (entries),
    .valid_i        (valid),
    .hit_o          (hit),
    .hit_ppn_o      (hit_ppn)
  );

  // Miss handling and flush selection
  itlb_ctrl #(.N(N_ENTRIES)) u_ctrl (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .vmem_on_i          (vmem_on_i),
    .icache_req_valid_i (icache_req_valid_i),
    .icache_req_vpn_i   (icache_req_vpn_i),
    .hit_i              (hit),
    .exc_q_i            (exc_q),
    .l2c_req_rdy_i      (l2c_req_rdy_i),
    .l2c_ans_valid_i    (l2c_ans_valid_i),
    .l2c_ans_exc_i      (l2c_ans_i.exc),
    .flush_type_i       (flush_type_i),
    .flush_asid_i       (flush_asid_i),
    .flush_page_i       (flush_page_i),
    .entries_i          (entries),
    .icache_req_rdy_o   (icache_req_rdy_o),
    .icache_ans_valid_o (icache_ans_valid_o),
    .l2c_req_valid_o    (l2c_req_valid_o),
    .l2c_req_vpn_o      (l2c_req_vpn_o),
    .exc_reg_en_o       (exc_reg_en),
    .exc_reg_clr_o      (exc_reg_clr),
    .replace_o          (replace),
    .flush_vec_o        (flush_vec)
  );

  // Entry storage, fill and flush
  itlb_entries #(.N(N_ENTRIES)) u_entries (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .replace_i     (replace),
    .fill_vpn_i    (l2c_req_vpn_o),
    .fill_asid_i   (current_asid_i),
    .fill_ans_i    (l2c_ans_i),
    .exc_reg_en_i  (exc_reg_en),
    .exc_reg_clr_i (exc_reg_clr),
    .flush_vec_i   (flush_vec),
    .entries_o     (entries),
    .valid_o       (valid),
    .exc_q_o       (exc_q)
  );

  // Answer select, identity when translation is off
  always_comb begin
    if (!vmem_on_i) begin
      icache_ans_o.ppn = ppn_t'(icache_req_vpn_i);
      icache_ans_o.exc = NoException;
    end else if (hit) begin
      icache_ans_o.ppn = hit_ppn;
      icache_ans_o.exc = NoException;
    end else begin
      // Walk fault, no translation
      icache_ans_o.ppn = '0;
      icache_ans_o.exc = exc_q;
    end
  end

endmodule

// File: tb_itlb.sv
module tb_itlb;

  import itlb_pkg::*;

  localparam int CLK_HALF = 20;
  localparam int TIMEOUT  = 40;

  logic       clk;
  logic       reset;
  logic       vmem_on;
  asid_t      cur_asid;
  tlb_flush_e flush_type;
  asid_t      flush_asid;
  vpn_t       flush_page;
  logic       req_valid;
  vpn_t       req_vpn;
  logic       req_rdy;
  logic       ans_valid;
  itlb_ans_t  ans;
  logic       l2_req_valid;
  vpn_t       l2_req_vpn;
  logic       l2_req_rdy;
  logic       l2_ans_valid;
  l2c_ans_t   l2_ans;
  logic [7:0] lfsr_q;

  itlb_top #(.N_ENTRIES(4)) u_dut (
    .clk_i              (clk),
    .reset_i            (reset),
    .vmem_on_i          (vmem_on),
    .current_asid_i     (cur_asid),
    .flush_type_i       (flush_type),
    .flush_asid_i       (flush_asid),
    .flush_page_i       (flush_page),
    .icache_req_valid_i (req_valid),
    .icache_req_vpn_i   (req_vpn),
    .icache_req_rdy_o   (req_rdy),
    .icache_ans_valid_o (ans_valid),
    .icache_ans_o       (ans),
    .l2c_req_valid_o    (l2_req_valid),
    .l2c_req_vpn_o      (l2_req_vpn),
    .l2c_req_rdy_i      (l2_req_rdy),
    .l2c_ans_valid_i    (l2_ans_valid),
    .l2c_ans_i          (l2_ans)
  );

  always #(CLK_HALF) clk = ~clk;

  // Fibonacci LFSR with taps 8 6 5 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // Delay of 0 to 7 cycles from three LFSR bits
  task automatic draw_delay(output int d);
    d = 0;
    for (int i = 0; i < 3; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      d = d * 2 + int'(lfsr_q[0]);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_ans(input string name, input itlb_ans_t exp, input itlb_ans_t got);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s answer: expected ppn %h exc %0d, actual ppn %h exc %0d",
                          name, exp.ppn, exp.exc, got.ppn, got.exc));
    end
  endtask

  task automatic check_l2c_req(input string name, input vpn_t exp, input vpn_t got);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s l2c request: expected vpn %h, actual vpn %h",
                          name, exp, got));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, got));
    end
  endtask

  // One clock with a bound on the whole wait
  task automatic step_with_timeout(input string name, input string what, inout int waited);
    @(posedge clk);
    waited++;
    if (waited > TIMEOUT) begin
      abort_run($sformatf("%s: timed out waiting for %s", name, what));
    end
  endtask

  // Cache request with the L2 model serving a miss
  task automatic do_request(input string name, input vpn_t vpn, input l2c_ans_t leaf,
                            input logic exp_miss, input itlb_ans_t exp_ans);
    int   waited;
    int   delay;
    logic walked;
    waited    = 0;
    req_valid = 1'b1;
    req_vpn   = vpn;
    do begin
      step_with_timeout(name, "an answer or an L2 request", waited);
    end while (!(ans_valid && req_rdy) && !l2_req_valid);
    walked = l2_req_valid;
    check_flag({name, " miss"}, exp_miss, walked);
    if (!walked && waited != 1) begin
      abort_run($sformatf("%s: answer did not come in the request cycle", name));
    end
    if (walked && waited != 2) begin
      abort_run($sformatf("%s: L2 request did not come one cycle after the miss", name));
    end
    if (walked) begin
      check_l2c_req(name, vpn, l2_req_vpn);
      // L2 busy while the request holds
      draw_delay(delay);
      repeat (delay + 1) @(negedge clk);
      l2_req_rdy = 1'b1;
      @(posedge clk);
      if (!l2_req_valid) begin
        abort_run($sformatf("%s: L2 request dropped before it was accepted", name));
      end
      @(negedge clk);
      l2_req_rdy = 1'b0;
      // Walk latency then a one-cycle leaf pulse
      draw_delay(delay);
      repeat (delay) @(negedge clk);
      l2_ans_valid = 1'b1;
      l2_ans       = leaf;
      @(negedge clk);
      l2_ans_valid = 1'b0;
      l2_ans       = '0;
      waited       = 0;
      do begin
        step_with_timeout(name, "the answer after the walk", waited);
      end while (!(ans_valid && req_rdy));
      if (waited != 1) begin
        abort_run($sformatf("%s: answer did not come in the cycle after the L2 answer", name));
      end
    end
    check_ans(name, exp_ans, ans);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  // Flush command lasts one cycle
  task automatic do_flush(input tlb_flush_e kind, input asid_t asid, input vpn_t page);
    flush_type = kind;
    flush_asid = asid;
    flush_page = page;
    @(negedge clk);
    flush_type = NoFlush;
  endtask

  task automatic set_mode(input logic on, input asid_t asid);
    vmem_on  = on;
    cur_asid = asid;
    @(negedge clk);
  endtask

  initial begin
    int          fd;
    int          n;
    int          line_no;
    int          ops;
    string       line;
    string       name;
    logic [7:0]  op_c;
    logic [26:0] vpn_f;
    logic [15:0] asid_f;
    logic [1:0]  flush_f;
    logic [43:0] ppn_f;
    logic [1:0]  size_f;
    logic        glob_f;
    logic [1:0]  exc_f;
    logic        miss_f;
    logic [43:0] exp_ppn_f;
    logic [1:0]  exp_exc_f;
    l2c_ans_t    leaf;
    itlb_ans_t   exp_ans;
    clk          = 1'b0;
    reset        = 1'b1;
    vmem_on      = 1'b0;
    cur_asid     = '0;
    flush_type   = NoFlush;
    flush_asid   = '0;
    flush_page   = '0;
    req_valid    = 1'b0;
    req_vpn      = '0;
    l2_req_rdy   = 1'b0;
    l2_ans_valid = 1'b0;
    l2_ans       = '0;
    lfsr_q       = 8'd61;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_flag("idle ready after reset", 1'b1, req_rdy);
    fd = $fopen("itlb_golden.txt", "r");
    if (fd == 0) begin
      abort_run("could not open itlb_golden.txt");
    end
    line_no = 0;
    ops     = 0;
    while ($fgets(line, fd) != 0) begin
      line_no++;
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", op_c, vpn_f, asid_f, flush_f,
                  ppn_f, size_f, glob_f, exc_f, miss_f, exp_ppn_f, exp_exc_f);
      if (n != 11) begin
        abort_run($sformatf("line %0d of the golden file is malformed", line_no));
      end
      name         = $sformatf("line %0d", line_no);
      leaf.ppn     = ppn_f;
      leaf.glob    = glob_f;
      leaf.size    = page_size_e'(size_f);
      leaf.exc     = exception_e'(exc_f);
      exp_ans.ppn  = exp_ppn_f;
      exp_ans.exc  = exception_e'(exp_exc_f);
      case (op_c)
        "R": do_request(name, vpn_t'(vpn_f), leaf, miss_f, exp_ans);
        "F": do_flush(tlb_flush_e'(flush_f), asid_t'(asid_f), vpn_t'(vpn_f));
        "V": set_mode(vpn_f[0], asid_t'(asid_f));
        default: abort_run($sformatf("line %0d has an unknown op", line_no));
      endcase
      ops++;
    end
    $fclose(fd);
    if (ops == 0) begin
      abort_run("the golden file held no operations");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// File: itlb_golden.txt
# op vpn asid flush | L2 leaf: ppn size glob exc | expected: miss ppn exc (all hex)
# R request, F flush (vpn is the page), V sets vmem from vpn bit 0 and the asid
R 0012345 0000 0 00000000000 0 0 0 0 00000012345 0
R 7ffffff 0000 0 00000000000 0 0 0 0 00007ffffff 0
V 0000001 0001 0 00000000000 0 0 0 0 00000000000 0
R 0000100 0000 0 00000abcd00 0 0 0 1 00000abcd00 0
R 0000100 0000 0 00000000000 0 0 0 0 00000abcd00 0
R 0040403 0000 0 00000200000 1 0 0 1 00000200003 0
R 00405ff 0000 0 00000000000 0 0 0 0 000002001ff 0
R 0080a07 0000 0 00000c00000 2 0 0 1 00000c00a07 0
R 00bff00 0000 0 00000000000 0 0 0 0 00000c3ff00 0
R 0000200 0000 0 00000000000 0 0 1 1 00000000000 1
R 0000200 0000 0 00000000000 0 0 2 1 00000000000 2
R 0000300 0000 0 00000333000 0 1 0 1 00000333000 0
V 0000001 0002 0 00000000000 0 0 0 0 00000000000 0
R 0000300 0000 0 00000000000 0 0 0 0 00000333000 0
R 0000100 0000 0 00000444000 0 0 0 1 00000444000 0
F 0000000 0001 1 00000000000 0 0 0 0 00000000000 0
R 0000300 0000 0 00000000000 0 0 0 0 00000333000 0
R 0000100 0000 0 00000000000 0 0 0 0 00000444000 0
V 0000001 0001 0 00000000000 0 0 0 0 00000000000 0
R 0040403 0000 0 00000200000 1 0 0 1 00000200003 0
F 00405ff 0000 2 00000000000 0 0 0 0 00000000000 0
R 0040403 0000 0 00000600000 1 0 0 1 00000600003 0
R 0000300 0000 0 00000000000 0 0 0 0 00000333000 0
F 0000000 0000 3 00000000000 0 0 0 0 00000000000 0
R 0000300 0000 0 00000333000 0 1 0 1 00000333000 0
R 0001000 0000 0 00000010000 0 0 0 1 00000010000 0
R 0001001 0000 0 00000011000 0 0 0 1 00000011000 0
R 0001002 0000 0 00000012000 0 0 0 1 00000012000 0
R 0001003 0000 0 00000013000 0 0 0 1 00000013000 0
R 0001004 0000 0 00000014000 0 0 0 1 00000014000 0
R 0001001 0000 0 00000000000 0 0 0 0 00000011000 0
R 0001000 0000 0 00000015000 0 0 0 1 00000015000 0

// File: compile.f
itlb_pkg.sv
itlb_lookup.sv
itlb_ctrl.sv
itlb_entries.sv
itlb_top.sv
tb_itlb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the ITLB testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_itlb -f compile.f -o tb_itlb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_itlb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$log"; then
  echo "Failure reported, see $log"
  exit 1
fi
exit 0
